/* Bender.yml */
package:
  name: cipher_device

sources:
  - hw/cipher_pkg.sv
  - hw/cmd_queue.sv
  - hw/key_schedule.sv
  - hw/key_store.sv
  - hw/round_engine.sv
  - hw/cipher_sequencer.sv
  - hw/cipher_device.sv
  - target: simulation
    files:
      - dv/tb_cipher_device.sv

/* cipher_device.f */
hw/cipher_pkg.sv
hw/cmd_queue.sv
hw/key_schedule.sv
hw/key_store.sv
hw/round_engine.sv
hw/cipher_sequencer.sv
hw/cipher_device.sv
dv/tb_cipher_device.sv

/* dv/tb_cipher_device.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cipher_device;

    localparam int BW = cipher_pkg::BLOCK_W;
    localparam int LW = cipher_pkg::LANE_W;

    logic          clk;
    logic          resetn;
    logic [BW-1:0] data_in;
    logic [cipher_pkg::MODE_W-1:0] mode;
    logic          data_valid;
    logic [BW-1:0] data_out;
    logic          done;

    integer rand_seed;
    int     check_errors;
    int     timeout_errors;

    // reference key store, mirrors what the last keygen should have written
    logic [BW-1:0] model_keys [cipher_pkg::NUM_ROUNDS];

    // results seen on done, and the results the model predicts
    logic [BW-1:0] done_q [$];
    logic [BW-1:0] exp_q [$];
    logic [BW-1:0] last_result;

    // carried between tests
    logic [BW-1:0] first_pt;
    logic [BW-1:0] first_ct;
    logic [BW-1:0] reuse_pt;
    logic [BW-1:0] reuse_ct;

    cipher_device cipher_device_i (
        .clk        (clk),
        .resetn     (resetn),
        .data_in    (data_in),
        .mode       (mode),
        .data_valid (data_valid),
        .data_out   (data_out),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // outputs are settled mid-cycle
    always @(negedge clk)
    begin
        if (resetn && done === 1'b1)
            done_q.push_back(data_out);
    end

    function automatic logic [BW-1:0] rotate_left(input logic [BW-1:0] x, input int n);
        return (x << n) | (x >> (BW - n));
    endfunction

    function automatic logic [BW-1:0] rotate_right(input logic [BW-1:0] x, input int n);
        return (x >> n) | (x << (BW - n));
    endfunction

    // key 0 is the seed, each next key rotates and mixes lane 0
    task automatic expand_keys(input logic [BW-1:0] seed);
        logic [BW-1:0] k;
        int i;
        k = seed;
        model_keys[0] = k;
        for (i = 0; i < cipher_pkg::NUM_ROUNDS - 1; i++)
        begin
            k = rotate_left(k, cipher_pkg::KEY_ROT);
            k[LW-1:0] = k[LW-1:0] ^ (cipher_pkg::KEY_MIX + LW'(i + 1));
            model_keys[i+1] = k;
        end
    endtask

    function automatic logic [BW-1:0] model_encrypt(input logic [BW-1:0] pt);
        logic [BW-1:0] s;
        logic [BW-1:0] k;
        int r;
        int l;
        s = pt;
        for (r = 0; r < cipher_pkg::NUM_ROUNDS; r++)
        begin
            k = model_keys[r];
            // lane add mod 2^32, rotate, xor
            for (l = 0; l < cipher_pkg::NUM_LANES; l++)
                s[LW*l +: LW] = s[LW*l +: LW] + k[LW*l +: LW];
            s = rotate_left(s, cipher_pkg::ROUND_ROT) ^ k;
        end
        return s;
    endfunction

    function automatic logic [BW-1:0] model_decrypt(input logic [BW-1:0] ct);
        logic [BW-1:0] s;
        logic [BW-1:0] k;
        int r;
        int l;
        s = ct;
        // keys walked from 15 down to 0
        for (r = cipher_pkg::NUM_ROUNDS - 1; r >= 0; r--)
        begin
            k = model_keys[r];
            s = rotate_right(s ^ k, cipher_pkg::ROUND_ROT);
            for (l = 0; l < cipher_pkg::NUM_LANES; l++)
                s[LW*l +: LW] = s[LW*l +: LW] - k[LW*l +: LW];
        end
        return s;
    endfunction

    task automatic make_block(output logic [BW-1:0] b);
        b = {$random(rand_seed), $random(rand_seed), $random(rand_seed), $random(rand_seed)};
    endtask

    task automatic check_value(input string name, input logic [BW-1:0] got,
                               input logic [BW-1:0] exp);
        assert (got === exp)
        else
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            check_errors++;
        end
    endtask

    // one strobe per call, left high for back-to-back bursts
    task automatic push_cmd(input logic [cipher_pkg::MODE_W-1:0] m, input logic [BW-1:0] d);
        @(negedge clk);
        mode       = m;
        data_in    = d;
        data_valid = 1'b1;
    endtask

    task automatic end_burst;
        @(negedge clk);
        data_valid = 1'b0;
    endtask

    // wait for every predicted result, then compare in order
    task automatic check_results(input string test, input int drain);
        int waited;
        int limit;
        int n;
        int i;
        waited = 0;
        limit  = 64 * exp_q.size() + 64;
        while (done_q.size() < exp_q.size() && waited < limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (done_q.size() < exp_q.size())
        begin
            $display("%s: timed out with %0d of %0d done pulses seen",
                     test, done_q.size(), exp_q.size());
            timeout_errors++;
        end
        // extra pulses would show up here
        repeat (drain) @(posedge clk);
        check_value({test, " done count"}, BW'(done_q.size()), BW'(exp_q.size()));
        n = (done_q.size() < exp_q.size()) ? done_q.size() : exp_q.size();
        for (i = 0; i < n; i++)
            check_value($sformatf("%s data_out[%0d]", test, i), done_q[i], exp_q[i]);
        if (n > 0)
            last_result = done_q[n-1];
        done_q.delete();
        exp_q.delete();
    endtask

    task automatic reset_state_test;
        check_value("done", BW'(done), '0);
        check_value("data_out", data_out, '0);
        check_value("key_we", BW'(cipher_device_i.key_we), '0);
        check_value("kg_start", BW'(cipher_device_i.kg_start), '0);
        check_value("eng_start", BW'(cipher_device_i.eng_start), '0);
        // idle, nothing in the queue
        repeat (5)
        begin
            @(negedge clk);
            check_value("done", BW'(done), '0);
        end
        check_value("idle done count", BW'(done_q.size()), '0);
    endtask

    task automatic keygen_encrypt_test;
        logic [BW-1:0] seed;
        make_block(seed);
        make_block(first_pt);
        push_cmd(cipher_pkg::MODE_KEYGEN, seed);
        push_cmd(cipher_pkg::MODE_ENC, first_pt);
        end_burst();
        expand_keys(seed);
        first_ct = model_encrypt(first_pt);
        exp_q.push_back(first_ct);
        check_results("encrypt", 4);
    endtask

    task automatic decrypt_test;
        logic [BW-1:0] ct2;
        make_block(ct2);
        push_cmd(cipher_pkg::MODE_DEC, first_ct);
        push_cmd(cipher_pkg::MODE_DEC, ct2);
        end_burst();
        // round trip must give back the plaintext
        exp_q.push_back(first_pt);
        exp_q.push_back(model_decrypt(ct2));
        check_results("decrypt", 4);
    endtask

    task automatic mixed_burst_test;
        logic [BW-1:0] a;
        logic [BW-1:0] b;
        logic [BW-1:0] s2;
        logic [BW-1:0] d;
        make_block(a);
        make_block(b);
        make_block(s2);
        make_block(reuse_pt);
        make_block(d);
        push_cmd(cipher_pkg::MODE_ENC, a);
        push_cmd(cipher_pkg::MODE_DEC, b);
        push_cmd(cipher_pkg::MODE_KEYGEN, s2);
        push_cmd(cipher_pkg::MODE_ENC, reuse_pt);
        push_cmd(cipher_pkg::MODE_DEC, d);
        push_cmd(cipher_pkg::MODE_ENC, a);
        end_burst();
        // old keys before the keygen, new keys after it
        exp_q.push_back(model_encrypt(a));
        exp_q.push_back(model_decrypt(b));
        expand_keys(s2);
        reuse_ct = model_encrypt(reuse_pt);
        exp_q.push_back(reuse_ct);
        exp_q.push_back(model_decrypt(d));
        exp_q.push_back(model_encrypt(a));
        check_results("mixed burst", 4);
    endtask

    task automatic rekey_test;
        logic [BW-1:0] s3;
        make_block(s3);
        push_cmd(cipher_pkg::MODE_KEYGEN, s3);
        push_cmd(cipher_pkg::MODE_ENC, reuse_pt);
        end_burst();
        expand_keys(s3);
        exp_q.push_back(model_encrypt(reuse_pt));
        check_results("rekey", 4);
        assert (last_result !== reuse_ct)
        else
        begin
            $display("ciphertext did not change after a new key generation");
            check_errors++;
        end
    endtask

    task automatic queue_full_test;
        logic [BW-1:0] s4;
        logic [BW-1:0] blk [11];
        int i;
        make_block(s4);
        for (i = 0; i < 11; i++)
            make_block(blk[i]);
        push_cmd(cipher_pkg::MODE_KEYGEN, s4);
        // ten fit while the schedule runs, the last one is lost
        for (i = 0; i < 11; i++)
            push_cmd(cipher_pkg::MODE_ENC, blk[i]);
        end_burst();
        expand_keys(s4);
        for (i = 0; i < 10; i++)
            exp_q.push_back(model_encrypt(blk[i]));
        check_results("queue full", 64);
    endtask

    initial
    begin
        rand_seed      = 32'h5ab2;
        check_errors   = 0;
        timeout_errors = 0;
        resetn         = 1'b0;
        data_valid     = 1'b0;
        mode           = '0;
        data_in        = '0;
        repeat (3) @(negedge clk);
        resetn = 1'b1;

        reset_state_test();
        keygen_encrypt_test();
        decrypt_test();
        mixed_burst_test();
        rekey_test();
        queue_full_test();

        $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/cipher_device.sv */
`timescale 1ns/1ps
`default_nettype none

module cipher_device (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     data_in,
    input  wire logic [cipher_pkg::MODE_W-1:0]      mode,
    input  wire logic                               data_valid,
    output logic [cipher_pkg::BLOCK_W-1:0]          data_out,
    output logic                                    done
);

    // queue head towards the sequencer
    logic                               head_ready;
    logic [cipher_pkg::MODE_W-1:0]      head_mode;
    logic [cipher_pkg::BLOCK_W-1:0]     head_data;
    logic                               pop;

    // key schedule and store
    logic                               kg_start;
    logic [cipher_pkg::BLOCK_W-1:0]     seed;
    logic                               kg_done;
    logic                               key_we;
    logic [cipher_pkg::KEY_IDX_W-1:0]   key_waddr;
    logic [cipher_pkg::BLOCK_W-1:0]     key_wdata;
    logic [cipher_pkg::KEY_IDX_W-1:0]   key_raddr;
    logic [cipher_pkg::BLOCK_W-1:0]     key_rdata;

    // engine
    logic                               eng_start;
    logic                               eng_decrypt;
    logic [cipher_pkg::BLOCK_W-1:0]     eng_data;
    logic [cipher_pkg::BLOCK_W-1:0]     result;
    logic                               eng_done;

    cmd_queue cmd_queue_i (
        .clk        (clk),
        .resetn     (resetn),
        .push_valid (data_valid),
        .push_mode  (mode),
        .push_data  (data_in),
        .pop        (pop),
        .head_ready (head_ready),
        .head_mode  (head_mode),
        .head_data  (head_data)
    );

    key_schedule key_schedule_i (
        .clk       (clk),
        .resetn    (resetn),
        .kg_start  (kg_start),
        .seed      (seed),
        .key_we    (key_we),
        .key_waddr (key_waddr),
        .key_wdata (key_wdata),
        .kg_done   (kg_done)
    );

    key_store key_store_i (
        .clk       (clk),
        .resetn    (resetn),
        .key_we    (key_we),
        .key_waddr (key_waddr),
        .key_wdata (key_wdata),
        .key_raddr (key_raddr),
        .key_rdata (key_rdata)
    );

    round_engine round_engine_i (
        .clk         (clk),
        .resetn      (resetn),
        .eng_start   (eng_start),
        .eng_decrypt (eng_decrypt),
        .eng_data    (eng_data),
        .key_rdata   (key_rdata),
        .key_raddr   (key_raddr),
        .result      (result),
        .eng_done    (eng_done)
    );

    cipher_sequencer cipher_sequencer_i (
        .clk         (clk),
        .resetn      (resetn),
        .head_ready  (head_ready),
        .head_mode   (head_mode),
        .head_data   (head_data),
        .kg_done     (kg_done),
        .eng_done    (eng_done),
        .result      (result),
        .pop         (pop),
        .kg_start    (kg_start),
        .seed        (seed),
        .eng_start   (eng_start),
        .eng_decrypt (eng_decrypt),
        .eng_data    (eng_data),
        .data_out    (data_out),
        .done        (done)
    );

endmodule

`default_nettype wire

/* hw/cipher_pkg.sv */
`default_nettype none

package cipher_pkg;

    // block and lane geometry
    localparam int BLOCK_W   = 128;
    localparam int LANE_W    = 32;
    localparam int NUM_LANES = 4;

    // sixteen rounds, one key per round
    localparam int NUM_ROUNDS = 16;
    localparam int KEY_IDX_W  = 4;

    // command queue sizing
    localparam int QUEUE_DEPTH = 10;
    localparam int QUEUE_CNT_W = 4;

    // command mode codes, 11 is not a command
    localparam int MODE_W = 2;
    localparam logic [MODE_W-1:0] MODE_ENC    = 2'b00;
    localparam logic [MODE_W-1:0] MODE_DEC    = 2'b01;
    localparam logic [MODE_W-1:0] MODE_KEYGEN = 2'b10;

    // round and key step constants
    localparam int ROUND_ROT = 13;
    localparam int KEY_ROT   = 29;
    localparam logic [LANE_W-1:0] KEY_MIX = 32'h9e37_79b9;

    // sequencer state codes
    localparam int SEQ_W = 2;
    localparam logic [SEQ_W-1:0] SEQ_IDLE   = 2'd0;
    localparam logic [SEQ_W-1:0] SEQ_KEYGEN = 2'd1;
    localparam logic [SEQ_W-1:0] SEQ_CIPHER = 2'd2;

    // one block seen as a whole word or as four lanes
    // lane 0 sits in the low 32 bits
    typedef union packed {
        logic [BLOCK_W-1:0]                word;
        logic [NUM_LANES-1:0][LANE_W-1:0]  lane;
    } block_t;

endpackage

`default_nettype wire

/* hw/cipher_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cipher_sequencer (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               head_ready,
    input  wire logic [cipher_pkg::MODE_W-1:0]      head_mode,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     head_data,
    input  wire logic                               kg_done,
    input  wire logic                               eng_done,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     result,
    output logic                                    pop,
    output logic                                    kg_start,
    output logic [cipher_pkg::BLOCK_W-1:0]          seed,
    output logic                                    eng_start,
    output logic                                    eng_decrypt,
    output logic [cipher_pkg::BLOCK_W-1:0]          eng_data,
    output logic [cipher_pkg::BLOCK_W-1:0]          data_out,
    output logic                                    done
);

    logic [cipher_pkg::SEQ_W-1:0] state;
    logic keys_valid;

    logic is_keygen;
    logic take;

    assign is_keygen = (head_mode == cipher_pkg::MODE_KEYGEN);

    // cipher commands stall at the head until keys exist
    assign take = (state == cipher_pkg::SEQ_IDLE) && head_ready
               && (is_keygen || keys_valid);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state       <= cipher_pkg::SEQ_IDLE;
            keys_valid  <= 1'b0;
            pop         <= 1'b0;
            kg_start    <= 1'b0;
            eng_start   <= 1'b0;
            eng_decrypt <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            // start pulses one cycle after the head is taken
            pop       <= take;
            kg_start  <= take && is_keygen;
            eng_start <= take && !is_keygen;
            done      <= eng_done;

            if (kg_done)
                keys_valid <= 1'b1;

            case (state)
                cipher_pkg::SEQ_IDLE:
                begin
                    if (take && is_keygen)
                    begin
                        state <= cipher_pkg::SEQ_KEYGEN;
                    end
                    else if (take)
                    begin
                        state       <= cipher_pkg::SEQ_CIPHER;
                        eng_decrypt <= (head_mode == cipher_pkg::MODE_DEC);
                    end
                end
                // wait for the schedule to finish
                cipher_pkg::SEQ_KEYGEN:
                begin
                    if (kg_done)
                        state <= cipher_pkg::SEQ_IDLE;
                end
                // wait for the engine
                cipher_pkg::SEQ_CIPHER:
                begin
                    if (eng_done)
                        state <= cipher_pkg::SEQ_IDLE;
                end
                default:
                begin
                    state <= cipher_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    // head word goes to whichever block will consume it
    always_ff @(posedge clk)
    begin
        if (take && is_keygen)
            seed <= head_data;
        if (take && !is_keygen)
            eng_data <= head_data;
    end

    // result register, held until the next job ends
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            data_out <= '0;
        else if (eng_done)
            data_out <= result;
    end

endmodule

`default_nettype wire

/* hw/cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_queue (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               push_valid,
    input  wire logic [cipher_pkg::MODE_W-1:0]      push_mode,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     push_data,
    input  wire logic                               pop,
    output logic                                    head_ready,
    output logic [cipher_pkg::MODE_W-1:0]           head_mode,
    output logic [cipher_pkg::BLOCK_W-1:0]          head_data
);

    // entry storage, slot 0 is the head
    logic [cipher_pkg::MODE_W-1:0]  mode_q [cipher_pkg::QUEUE_DEPTH];
    logic [cipher_pkg::BLOCK_W-1:0] data_q [cipher_pkg::QUEUE_DEPTH];
    logic [cipher_pkg::QUEUE_CNT_W-1:0] fill;

    logic full;
    logic do_push;
    logic do_pop;
    logic [cipher_pkg::QUEUE_CNT_W-1:0] wr_slot;

    assign full = (fill == cipher_pkg::QUEUE_CNT_W'(cipher_pkg::QUEUE_DEPTH));
    assign head_ready = (fill != '0);

    // mode 11 and pushes into a full queue vanish silently
    assign do_push = push_valid && !full && (push_mode != 2'b11);
    assign do_pop  = pop && head_ready;

    // a pop frees one slot below the tail
    assign wr_slot = do_pop ? fill - 1'b1 : fill;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            fill <= '0;
        end
        else if (do_push && !do_pop)
        begin
            fill <= fill + 1'b1;
        end
        else if (do_pop && !do_push)
        begin
            fill <= fill - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_pop)
        begin
            // shift everything down by one
            for (int i = 0; i < cipher_pkg::QUEUE_DEPTH - 1; i++)
            begin
                mode_q[i] <= mode_q[i+1];
                data_q[i] <= data_q[i+1];
            end
        end
        if (do_push)
        begin
            mode_q[wr_slot] <= push_mode;
            data_q[wr_slot] <= push_data;
        end
    end

    assign head_mode = mode_q[0];
    assign head_data = data_q[0];

endmodule

`default_nettype wire

/* hw/key_schedule.sv */
`timescale 1ns/1ps
`default_nettype none

module key_schedule (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               kg_start,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     seed,
    output logic                                    key_we,
    output logic [cipher_pkg::KEY_IDX_W-1:0]        key_waddr,
    output logic [cipher_pkg::BLOCK_W-1:0]          key_wdata,
    output logic                                    kg_done
);

    // running key and the index it will be written to
    cipher_pkg::block_t run_key;
    cipher_pkg::block_t next_key;
    logic [cipher_pkg::KEY_IDX_W-1:0] step;
    logic active;

    // step counter padded to lane width
    logic [cipher_pkg::LANE_W-1:0] step_ext;

    assign step_ext = {{(cipher_pkg::LANE_W - cipher_pkg::KEY_IDX_W){1'b0}}, step};

    always_comb
    begin
        // rotate the whole key
        next_key.word = (run_key.word << cipher_pkg::KEY_ROT)
                      | (run_key.word >> (cipher_pkg::BLOCK_W - cipher_pkg::KEY_ROT));
        // lane 0 picks up the mix constant plus i+1
        next_key.lane[0] = next_key.lane[0] ^ (cipher_pkg::KEY_MIX + step_ext + 1'b1);
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            active <= 1'b0;
            step   <= '0;
        end
        else if (kg_start)
        begin
            active <= 1'b1;
            step   <= '0;
        end
        else if (active)
        begin
            step <= step + 1'b1;
            // all ones means key 15 is going out now
            if (&step)
                active <= 1'b0;
        end
    end

    // seed is key 0, later keys follow the chain
    always_ff @(posedge clk)
    begin
        if (kg_start)
            run_key.word <= seed;
        else if (active)
            run_key <= next_key;
    end

    // one write per active cycle
    assign key_we    = active;
    assign key_waddr = step;
    assign key_wdata = run_key.word;
    assign kg_done   = active && (&step);

endmodule

`default_nettype wire

/* hw/key_store.sv */
`timescale 1ns/1ps
`default_nettype none

module key_store (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               key_we,
    input  wire logic [cipher_pkg::KEY_IDX_W-1:0]   key_waddr,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     key_wdata,
    input  wire logic [cipher_pkg::KEY_IDX_W-1:0]   key_raddr,
    output logic [cipher_pkg::BLOCK_W-1:0]          key_rdata
);

    // one round key per entry
    logic [cipher_pkg::BLOCK_W-1:0] keys [cipher_pkg::NUM_ROUNDS];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            // no stale keys after reset
            for (int i = 0; i < cipher_pkg::NUM_ROUNDS; i++)
                keys[i] <= '0;
        end
        else if (key_we)
        begin
            keys[key_waddr] <= key_wdata;
        end
    end

    // engine reads in the same cycle it addresses
    assign key_rdata = keys[key_raddr];

endmodule

`default_nettype wire

/* hw/round_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module round_engine (
    input  wire logic                               clk,
    input  wire logic                               resetn,
    input  wire logic                               eng_start,
    input  wire logic                               eng_decrypt,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     eng_data,
    input  wire logic [cipher_pkg::BLOCK_W-1:0]     key_rdata,
    output logic [cipher_pkg::KEY_IDX_W-1:0]        key_raddr,
    output logic [cipher_pkg::BLOCK_W-1:0]          result,
    output logic                                    eng_done
);

    // control
    logic busy;
    logic decrypt_q;
    logic [cipher_pkg::KEY_IDX_W-1:0] round_cnt;

    // datapath
    cipher_pkg::block_t state_q;
    cipher_pkg::block_t key_b;
    cipher_pkg::block_t add_b;
    cipher_pkg::block_t fwd_b;
    cipher_pkg::block_t xor_b;
    cipher_pkg::block_t rot_b;
    cipher_pkg::block_t inv_b;
    cipher_pkg::block_t next_b;

    // decrypt walks the keys backwards, ~cnt is 15 - cnt
    assign key_raddr = decrypt_q ? ~round_cnt : round_cnt;

    always_comb
    begin
        key_b.word = key_rdata;

        // forward round
        // lane add, then rotate left, then xor
        for (int i = 0; i < cipher_pkg::NUM_LANES; i++)
            add_b.lane[i] = state_q.lane[i] + key_b.lane[i];
        fwd_b.word = ((add_b.word << cipher_pkg::ROUND_ROT)
                   | (add_b.word >> (cipher_pkg::BLOCK_W - cipher_pkg::ROUND_ROT)))
                   ^ key_b.word;

        // inverse round undoes the steps in reverse order
        xor_b.word = state_q.word ^ key_b.word;
        rot_b.word = (xor_b.word >> cipher_pkg::ROUND_ROT)
                   | (xor_b.word << (cipher_pkg::BLOCK_W - cipher_pkg::ROUND_ROT));
        for (int i = 0; i < cipher_pkg::NUM_LANES; i++)
            inv_b.lane[i] = rot_b.lane[i] - key_b.lane[i];

        next_b = decrypt_q ? inv_b : fwd_b;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy      <= 1'b0;
            decrypt_q <= 1'b0;
            round_cnt <= '0;
        end
        else if (eng_start)
        begin
            busy      <= 1'b1;
            decrypt_q <= eng_decrypt;
            round_cnt <= '0;
        end
        else if (busy)
        begin
            round_cnt <= round_cnt + 1'b1;
            if (eng_done)
                busy <= 1'b0;
        end
    end

    // block state, loaded on start and advanced one round per cycle
    always_ff @(posedge clk)
    begin
        if (eng_start)
            state_q.word <= eng_data;
        else if (busy)
            state_q <= next_b;
    end

    // last round output goes straight out with the done pulse
    assign result   = next_b.word;
    assign eng_done = busy && (&round_cnt);

endmodule

`default_nettype wire
